// ==== common/bkram_pkg.sv ====
// Backup RAM save/load engine shared geometry and enumerations
package bkram_pkg;

	////////////////////////////////////////////////////////////
	// Sector geometry
	////////////////////////////////////////////////////////////

	localparam int SECTOR_WORDS = 256;  // 16-bit words per SD sector
	localparam int SECTOR_BYTES = 512;
	localparam int BRAM_SECTORS = 16;   // 8 KB of internal backup RAM

	// Byte address into the internal RAM
	localparam int BRAM_ADDR_W = 13;

	// SD sector number, internal sectors first then cart sectors
	localparam int LBA_W = 11;

	////////////////////////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		BK_IDLE       = 3'd0,
		BK_BRAM       = 3'd1, // Sectors 0..15 straight to internal RAM
		BK_CART_SD    = 3'd2, // SD read into the buffer on a cart load
		BK_CART_COPY  = 3'd3, // Buffer and external memory exchange
		BK_CART_SD_WR = 3'd4  // SD write from the buffer on a cart save
	} bk_state_e;

	////////////////////////////////////////////////////////////
	// Transfer direction
	////////////////////////////////////////////////////////////

	// Save moves RAM to SD, load moves SD to RAM
	typedef enum logic {
		OP_SAVE = 1'b0,
		OP_LOAD = 1'b1
	} bk_op_e;

endpackage

// ==== design/sector_ram.sv ====
// Dual-width sector RAM with a byte port and a 16-bit word port on one store
`timescale 1ns/10ps

module sector_ram #(
	parameter int SECTORS = 16
) (
	input  logic                                                clk_sys,
	// Byte side
	input  logic [$clog2(SECTORS*bkram_pkg::SECTOR_BYTES)-1:0] a_addr,
	input  logic [7:0]                                          a_wdata,
	input  logic                                                a_we,
	output logic [7:0]                                          a_rdata,
	// Word side
	input  logic [$clog2(SECTORS*bkram_pkg::SECTOR_WORDS)-1:0] b_addr,
	input  logic [15:0]                                         b_wdata,
	input  logic                                                b_we,
	output logic [15:0]                                         b_rdata
);
	import bkram_pkg::*;

	localparam int DEPTH  = SECTORS * SECTOR_WORDS;
	localparam int WORD_W = $clog2(DEPTH);
	localparam int BYTE_W = $clog2(SECTORS * SECTOR_BYTES);

	logic [15:0] mem [DEPTH];

	logic [WORD_W-1:0] a_word;
	logic              a_hi;   // Odd byte sits in the high half

	assign a_word = a_addr[BYTE_W-1:1];
	assign a_hi   = a_addr[0];

	////////////////////////////////////////////////////////////
	// Storage, both ports registered
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (a_we) begin
			if (a_hi) mem[a_word][15:8] <= a_wdata;
			else      mem[a_word][7:0]  <= a_wdata;
		end
		if (b_we) mem[b_addr] <= b_wdata;   // Word side wins a clash

		a_rdata <= a_hi ? mem[a_word][15:8] : mem[a_word][7:0];
		b_rdata <= mem[b_addr];
	end

endmodule

// ==== design/cart_copier.sv ====
// Byte copier between the sector buffer and the external cart memory port
`timescale 1ns/10ps

module cart_copier (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        copy_start,
	input  bkram_pkg::bk_op_e           copy_op,
	input  logic [bkram_pkg::LBA_W-1:0] cart_sector,
	input  logic [7:0]                  buf_rdata,
	input  logic                        mem_done,
	input  logic [7:0]                  mem_rdata,
	output logic                        copy_done,
	output logic [8:0]                  buf_addr,
	output logic [7:0]                  buf_wdata,
	output logic                        buf_we,
	output logic                        mem_rd,
	output logic                        mem_wr,
	output logic [bkram_pkg::LBA_W+8:0] mem_addr,
	output logic [7:0]                  mem_wdata
);
	import bkram_pkg::*;

	typedef enum logic [1:0] {
		C_IDLE,
		C_NEXT,   // Buffer read in flight, request raised at the end
		C_MEM     // Waiting on mem_done
	} copy_state_e;

	copy_state_e state;
	bk_op_e      op;
	logic [8:0]  cnt;   // Byte offset in the sector

	assign buf_addr  = cnt;
	assign buf_wdata = mem_rdata;
	assign buf_we    = (state == C_MEM) & mem_done & (op == OP_SAVE);
	assign mem_addr  = {cart_sector, cnt};
	assign mem_wdata = buf_rdata;   // Held steady while the address holds

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= C_IDLE;
			op        <= OP_SAVE;
			cnt       <= '0;
			mem_rd    <= 1'b0;
			mem_wr    <= 1'b0;
			copy_done <= 1'b0;
		end else begin
			copy_done <= 1'b0;
			case (state)
				C_IDLE: begin
					if (copy_start) begin
						op    <= copy_op;
						cnt   <= '0;
						state <= C_NEXT;
					end
				end
				C_NEXT: begin
					mem_wr <= (op == OP_LOAD);
					mem_rd <= (op == OP_SAVE);
					state  <= C_MEM;
				end
				C_MEM: begin
					if (mem_done) begin
						mem_rd <= 1'b0;
						mem_wr <= 1'b0;
						if (&cnt) begin
							copy_done <= 1'b1;   // Last byte of the sector
							state     <= C_IDLE;
						end else begin
							cnt   <= cnt + 1'b1;
							state <= C_NEXT;
						end
					end
				end
				default: state <= C_IDLE;
			endcase
		end
	end

endmodule

// ==== bkram_ctrl/save_tracker.sv ====
// Save tracker for mount enable, pending save flag and transfer triggers
`timescale 1ns/10ps

module save_tracker (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              save_mount,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic              bk_load,
	input  logic              bk_save,
	input  logic              autosave_en,
	input  logic              osd_status,
	input  logic              bram_we,
	input  logic              cart_ram_wr,
	input  logic              xfer_busy,
	output logic              xfer_start,
	output bkram_pkg::bk_op_e xfer_op,
	output logic              bk_enabled,
	output logic              save_pending
);
	import bkram_pkg::*;

	logic old_mount;
	logic old_load;
	logic old_save;
	logic old_osd;
	logic old_change;
	logic change;
	logic load_edge;
	logic save_edge;
	logic auto_edge;
	logic idle;

	assign change    = bram_we | cart_ram_wr;   // Core or cart RAM write
	assign load_edge = bk_load & ~old_load;
	assign save_edge = bk_save & ~old_save;
	assign auto_edge = osd_status & ~old_osd & autosave_en & save_pending;
	assign idle      = ~xfer_busy & ~xfer_start;  // Start pulse not yet seen as busy

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_mount    <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_osd      <= 1'b0;
			old_change   <= 1'b0;
			bk_enabled   <= 1'b0;
			save_pending <= 1'b0;
			xfer_start   <= 1'b0;
			xfer_op      <= OP_SAVE;
		end else begin
			old_mount  <= save_mount;
			old_load   <= bk_load;
			old_save   <= bk_save;
			old_osd    <= osd_status;
			old_change <= change;

			// New save image on the way, enabled again once it is writable
			if (save_mount & ~old_mount) bk_enabled <= 1'b0;
			if (save_mount & img_mounted & ~img_readonly) bk_enabled <= 1'b1;

			xfer_start <= 1'b0;
			if (bk_enabled & idle & (load_edge | save_edge | auto_edge)) begin
				xfer_start <= 1'b1;
				xfer_op    <= load_edge ? OP_LOAD : OP_SAVE;  // Load wins
			end

			if (xfer_start) save_pending <= 1'b0;
			if (change & ~old_change) save_pending <= 1'b1;
		end
	end

endmodule

// ==== bkram_ctrl/bkram_ctrl.sv ====
// Backup RAM transfer sequencer stepping all sectors over the SD port
`timescale 1ns/10ps

module bkram_ctrl #(
	parameter int CART_SECTORS = 4
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        xfer_start,
	input  bkram_pkg::bk_op_e           xfer_op,
	input  logic                        cart_en,
	input  logic                        sd_ack,
	input  logic                        copy_done,
	output logic                        xfer_busy,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic [bkram_pkg::LBA_W-1:0] sd_lba,
	output logic [bkram_pkg::LBA_W-1:0] cart_sector,
	output logic                        copy_start,
	output bkram_pkg::bk_op_e           copy_op
);
	import bkram_pkg::*;

	localparam logic [LBA_W-1:0] CART_BASE = LBA_W'(BRAM_SECTORS);
	localparam logic [LBA_W-1:0] BRAM_LAST = LBA_W'(BRAM_SECTORS - 1);
	localparam logic [LBA_W-1:0] CART_LAST = LBA_W'(BRAM_SECTORS + CART_SECTORS - 1);

	bk_state_e state;
	bk_op_e    op;
	logic      cart_on;   // Cart phase wanted for this transfer
	logic      old_ack;
	logic      ack_rise;
	logic      ack_fall;

	assign ack_rise = ~old_ack & sd_ack;
	assign ack_fall = old_ack & ~sd_ack;   // Sector finished on the host side

	assign xfer_busy   = (state != BK_IDLE);
	assign cart_sector = sd_lba - CART_BASE;
	assign copy_op     = op;

	////////////////////////////////////////////////////////////
	// Sector sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= BK_IDLE;
			op         <= OP_SAVE;
			cart_on    <= 1'b0;
			old_ack    <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			copy_start <= 1'b0;
		end else begin
			old_ack    <= sd_ack;
			copy_start <= 1'b0;

			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (xfer_start) begin
						op      <= xfer_op;
						cart_on <= cart_en;
						sd_lba  <= '0;
						sd_rd   <= (xfer_op == OP_LOAD);
						sd_wr   <= (xfer_op == OP_SAVE);
						state   <= BK_BRAM;
					end
				end

				BK_BRAM: begin
					if (ack_fall) begin
						sd_lba <= sd_lba + 1'b1;
						if (sd_lba != BRAM_LAST) begin
							sd_rd <= (op == OP_LOAD);
							sd_wr <= (op == OP_SAVE);
						end else if (!cart_on) begin
							state <= BK_IDLE;
						end else if (op == OP_LOAD) begin
							sd_rd <= 1'b1;   // First cart sector into the buffer
							state <= BK_CART_SD;
						end else begin
							copy_start <= 1'b1; // Fill buffer from memory first
							state      <= BK_CART_COPY;
						end
					end
				end

				BK_CART_SD: begin
					if (ack_fall) begin
						copy_start <= 1'b1;
						state      <= BK_CART_COPY;
					end
				end

				BK_CART_COPY: begin
					if (copy_done) begin
						if (op == OP_SAVE) begin
							sd_wr <= 1'b1;
							state <= BK_CART_SD_WR;
						end else if (sd_lba == CART_LAST) begin
							state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= 1'b1;
							state  <= BK_CART_SD;
						end
					end
				end

				BK_CART_SD_WR: begin
					if (ack_fall) begin
						if (sd_lba == CART_LAST) begin
							state <= BK_IDLE;
						end else begin
							sd_lba     <= sd_lba + 1'b1;
							copy_start <= 1'b1;
							state      <= BK_CART_COPY;
						end
					end
				end

				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

// ==== design/bkram_top.sv ====
// Backup RAM save/load top level joining tracker, sequencer, RAMs and cart copier
`timescale 1ns/10ps

module bkram_top #(
	parameter int CART_SECTORS = 4
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              save_mount,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic                              cart_en,
	input  logic                              bk_load,
	input  logic                              bk_save,
	input  logic                              autosave_en,
	input  logic                              osd_status,
	input  logic                              cart_ram_wr,
	// SD sector port
	input  logic                              sd_ack,
	input  logic                              sd_buff_wr,
	input  logic [7:0]                        sd_buff_addr,
	input  logic [15:0]                       sd_buff_dout,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic [bkram_pkg::LBA_W-1:0]       sd_lba,
	output logic [15:0]                       sd_buff_din,
	// Core byte access
	input  logic [bkram_pkg::BRAM_ADDR_W-1:0] bram_addr,
	input  logic [7:0]                        bram_wdata,
	input  logic                              bram_we,
	output logic [7:0]                        bram_rdata,
	// External cart memory
	input  logic                              mem_done,
	input  logic [7:0]                        mem_rdata,
	output logic                              mem_rd,
	output logic                              mem_wr,
	output logic [bkram_pkg::LBA_W+8:0]       mem_addr,
	output logic [7:0]                        mem_wdata,
	// Status
	output logic                              bk_busy,
	output logic                              bk_enabled,
	output logic                              save_pending
);
	import bkram_pkg::*;

	logic             xfer_start;
	logic             xfer_busy;
	bk_op_e           xfer_op;
	logic             copy_start;
	logic             copy_done;
	bk_op_e           copy_op;
	logic [LBA_W-1:0] cart_sector;

	logic        in_bram;        // Current sector lives in internal RAM
	logic [11:0] bram_word_addr;
	logic [15:0] bram_sd_rdata;
	logic [15:0] buf_sd_rdata;

	logic [8:0] buf_addr;
	logic [7:0] buf_wdata;
	logic [7:0] buf_rdata;
	logic       buf_we;

	assign bk_busy        = xfer_busy;
	assign in_bram        = (sd_lba < LBA_W'(BRAM_SECTORS));
	assign bram_word_addr = {sd_lba[3:0], sd_buff_addr};
	assign sd_buff_din    = in_bram ? bram_sd_rdata : buf_sd_rdata;

	save_tracker u_tracker (
		.clk_sys(clk_sys), .reset(reset),
		.save_mount(save_mount), .img_mounted(img_mounted), .img_readonly(img_readonly),
		.bk_load(bk_load), .bk_save(bk_save),
		.autosave_en(autosave_en), .osd_status(osd_status),
		.bram_we(bram_we), .cart_ram_wr(cart_ram_wr), .xfer_busy(xfer_busy),
		.xfer_start(xfer_start), .xfer_op(xfer_op),
		.bk_enabled(bk_enabled), .save_pending(save_pending)
	);

	bkram_ctrl #(.CART_SECTORS(CART_SECTORS)) u_ctrl (
		.clk_sys(clk_sys), .reset(reset),
		.xfer_start(xfer_start), .xfer_op(xfer_op), .cart_en(cart_en),
		.sd_ack(sd_ack), .copy_done(copy_done), .xfer_busy(xfer_busy),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba), .cart_sector(cart_sector),
		.copy_start(copy_start), .copy_op(copy_op)
	);

	sector_ram #(.SECTORS(BRAM_SECTORS)) bram_store (
		.clk_sys(clk_sys),
		.a_addr(bram_addr), .a_wdata(bram_wdata), .a_we(bram_we), .a_rdata(bram_rdata),
		.b_addr(bram_word_addr), .b_wdata(sd_buff_dout),
		.b_we(sd_buff_wr & sd_ack & in_bram), .b_rdata(bram_sd_rdata)
	);

	sector_ram #(.SECTORS(1)) sector_buf (
		.clk_sys(clk_sys),
		.a_addr(buf_addr), .a_wdata(buf_wdata), .a_we(buf_we), .a_rdata(buf_rdata),
		.b_addr(sd_buff_addr), .b_wdata(sd_buff_dout),
		.b_we(sd_buff_wr & sd_ack & ~in_bram), .b_rdata(buf_sd_rdata)
	);

	cart_copier u_copier (
		.clk_sys(clk_sys), .reset(reset),
		.copy_start(copy_start), .copy_op(copy_op), .cart_sector(cart_sector),
		.buf_rdata(buf_rdata), .mem_done(mem_done), .mem_rdata(mem_rdata),
		.copy_done(copy_done), .buf_addr(buf_addr), .buf_wdata(buf_wdata), .buf_we(buf_we),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

endmodule

// ==== tests/bkram_chk.sv ====
// Handshake checker for the SD sector port and the cart memory port
`timescale 1ns/10ps

module bkram_chk (
	input logic                        clk_sys,
	input logic                        reset,
	input logic                        sd_rd,
	input logic                        sd_wr,
	input logic                        sd_ack,
	input logic [bkram_pkg::LBA_W-1:0] sd_lba,
	input logic                        mem_rd,
	input logic                        mem_wr,
	input logic                        mem_done,
	input logic [bkram_pkg::LBA_W+8:0] mem_addr,
	input logic [7:0]                  mem_wdata,
	input logic                        bk_busy
);

	sd_one_dir: assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else $error("SD read and write requested together");

	// Request and sector number hold until the host answers
	sd_hold: assert property (@(posedge clk_sys) disable iff (reset)
		((sd_rd || sd_wr) && !sd_ack) |=> $stable(sd_rd) && $stable(sd_wr) && $stable(sd_lba))
		else $error("SD request dropped or changed before sd_ack");

	mem_hold: assert property (@(posedge clk_sys) disable iff (reset)
		((mem_rd || mem_wr) && !mem_done) |=> $stable({mem_rd, mem_wr, mem_addr, mem_wdata}))
		else $error("Memory request dropped or changed before mem_done");

	// Engine quiet outside a transfer
	idle_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		!bk_busy |-> !(sd_rd || sd_wr || mem_rd || mem_wr))
		else $error("SD or memory request while bk_busy is low");

endmodule

bind bkram_top bkram_chk u_chk (.*);

// ==== tests/bkram_tb.sv ====
// Directed testbench for the backup RAM engine with SD host and cart memory models
`timescale 1ns/10ps

module bkram_tb;
	import bkram_pkg::*;

	localparam int CART_SECTORS = 4;
	localparam int N_SECT       = BRAM_SECTORS + CART_SECTORS;
	localparam int BRAM_BYTES   = BRAM_SECTORS * SECTOR_BYTES;
	localparam int CART_BYTES   = CART_SECTORS * SECTOR_BYTES;
	// Worst sector is ack delay plus 256 words, a cart sector adds 512 memory accesses
	localparam int SECT_CYC  = 8 + SECTOR_WORDS + 4;
	localparam int XFER_CYC  = N_SECT * SECT_CYC + CART_SECTORS * SECTOR_BYTES * 10;
	localparam int TOTAL_CYC = 4 * XFER_CYC + 3 * BRAM_BYTES + 1000;

	logic clk_sys = 1'b0;
	logic reset   = 1'b1;
	logic save_mount = 1'b0, img_mounted = 1'b0, img_readonly = 1'b0, cart_en = 1'b0;
	logic bk_load = 1'b0, bk_save = 1'b0, autosave_en = 1'b0, osd_status = 1'b0;
	logic cart_ram_wr = 1'b0, sd_ack = 1'b0, sd_buff_wr = 1'b0, bram_we = 1'b0, mem_done = 1'b0;
	logic [7:0]             sd_buff_addr = '0;
	logic [15:0]            sd_buff_dout = '0;
	logic [BRAM_ADDR_W-1:0] bram_addr    = '0;
	logic [7:0]             bram_wdata = '0, mem_rdata = '0;
	logic sd_rd, sd_wr, bk_busy, bk_enabled, save_pending, mem_rd, mem_wr;
	logic [LBA_W-1:0]       sd_lba;
	logic [15:0]            sd_buff_din;
	logic [7:0]             bram_rdata, mem_wdata;
	logic [LBA_W+8:0]       mem_addr;

	integer      seed = 32'hfd5d_94f4;
	int          req_lba[$];   // Every SD request in order
	bit          req_wr[$];
	int          mem_reqs = 0;
	logic [15:0] rx_words [N_SECT * SECTOR_WORDS];
	logic [7:0]  cart_mem [CART_BYTES];

	bkram_top #(.CART_SECTORS(CART_SECTORS)) dut (.*);

	initial begin
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Expected data
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] load_word(input int s, input int k);
		return 16'(s * 4951 + k * 515) ^ 16'hc33c;
	endfunction

	function automatic logic [7:0] load_byte(input int s, input int j);
		logic [15:0] w;
		w = load_word(s, j / 2);
		return j[0] ? w[15:8] : w[7:0];   // Odd byte in the high half
	endfunction

	function automatic logic [7:0] core_byte(input int a);
		return 8'(a * 7 + a / 256 * 29) ^ 8'h69;
	endfunction

	// Cart memory contents ahead of a save
	function automatic logic [7:0] cart_byte(input int i);
		return 8'(i * 13 + i / 256 * 71) ^ 8'ha5;
	endfunction

	function automatic logic [15:0] save_word(input int s, input int k);
		int b;
		b = s * SECTOR_BYTES + 2 * k;
		if (s >= BRAM_SECTORS) begin
			b = b - BRAM_BYTES;   // Byte index in cart memory
			return {cart_byte(b + 1), cart_byte(b)};
		end
		return {core_byte(b + 1), core_byte(b)};
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp));
	endtask

	task automatic compare_requests(input int base, input int count, input bit wr);
		check("SD request count", 32'(req_lba.size() - base), 32'(count));
		for (int i = 0; i < count; i++) begin
			check($sformatf("sd_lba of request %0d", i), 32'(req_lba[base + i]), 32'(i));
			check($sformatf("sd_wr of request %0d", i), 32'(req_wr[base + i]), 32'(wr));
		end
	endtask

	task automatic wait_transfer();
		while (!bk_busy) @(negedge clk_sys);
		while (bk_busy) @(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// SD host and cart memory models
	////////////////////////////////////////////////////////////

	initial begin
		int lba;
		bit wr;
		int delay;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				lba = int'(sd_lba);
				wr  = sd_wr;
				if (lba >= N_SECT) fail_run("SD request for a sector past the cart area");
				req_lba.push_back(lba);
				req_wr.push_back(wr);
				delay = 1 + int'($unsigned($random(seed)) % 8);
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				for (int k = 0; k <= SECTOR_WORDS; k++) begin
					if (k > 0) begin
						@(negedge clk_sys);
						if (wr) rx_words[lba * SECTOR_WORDS + k - 1] = sd_buff_din; // One clock late
					end
					if (k < SECTOR_WORDS) begin
						sd_buff_addr = 8'(k);
						sd_buff_dout = load_word(lba, k);
						sd_buff_wr   = !wr;
					end
				end
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;
			end
		end
	end

	initial begin
		int idx;
		int delay;
		forever begin
			@(negedge clk_sys);
			if (mem_rd || mem_wr) begin
				mem_reqs++;
				idx = int'(mem_addr);
				if (idx >= CART_BYTES) fail_run("Memory access outside the cart area");
				delay = 1 + int'($unsigned($random(seed)) % 5);
				repeat (delay - 1) @(negedge clk_sys);
				mem_done  = 1'b1;
				mem_rdata = cart_mem[idx];
				if (mem_wr) cart_mem[idx] = mem_wdata;
				@(negedge clk_sys);
				mem_done = 1'b0;
			end
		end
	end

	initial begin
		#(TOTAL_CYC * 100);
		fail_run("Timeout: a transfer or handshake did not finish in time");
	end

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic mount_gating();
		bk_load = 1'b1;
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_load = 1'b0;
		bk_save = 1'b0;
		repeat (10) @(negedge clk_sys);
		check("SD requests before mount", 32'(req_lba.size()), 32'd0);
		check("bk_busy", 32'(bk_busy), 32'd0);
		save_mount   = 1'b1;   // Read-only image first
		img_mounted  = 1'b1;
		img_readonly = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		@(negedge clk_sys);
		check("bk_enabled", 32'(bk_enabled), 32'd0);
		save_mount = 1'b0;
		@(negedge clk_sys);
		save_mount   = 1'b1;
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		check("bk_enabled", 32'(bk_enabled), 32'd1);
	endtask

	task automatic full_load();
		int base;
		base    = req_lba.size();
		cart_en = 1'b1;
		bk_load = 1'b1;
		@(negedge clk_sys);
		bk_load = 1'b0;
		wait_transfer();
		compare_requests(base, N_SECT, 1'b0);
		for (int a = 0; a <= BRAM_BYTES; a++) begin
			if (a > 0)
				check($sformatf("bram_rdata @%0d", a - 1), 32'(bram_rdata),
					32'(load_byte((a - 1) / SECTOR_BYTES, (a - 1) % SECTOR_BYTES)));
			if (a < BRAM_BYTES) bram_addr = BRAM_ADDR_W'(a);
			@(negedge clk_sys);
		end
		for (int i = 0; i < CART_BYTES; i++)
			check($sformatf("cart memory @%0d", i), 32'(cart_mem[i]),
				32'(load_byte(BRAM_SECTORS + i / SECTOR_BYTES, i % SECTOR_BYTES)));
	endtask

	task automatic full_save();
		int base;
		for (int a = 0; a < BRAM_BYTES; a++) begin
			bram_addr  = BRAM_ADDR_W'(a);
			bram_wdata = core_byte(a);
			bram_we    = 1'b1;
			@(negedge clk_sys);
		end
		bram_we = 1'b0;
		for (int i = 0; i < CART_BYTES; i++)
			cart_mem[i] = cart_byte(i);
		base    = req_lba.size();
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		wait_transfer();
		compare_requests(base, N_SECT, 1'b1);
		for (int s = 0; s < N_SECT; s++)
			for (int k = 0; k < SECTOR_WORDS; k++)
				check($sformatf("sd_buff_din sector %0d word %0d", s, k),
					32'(rx_words[s * SECTOR_WORDS + k]), 32'(save_word(s, k)));
	endtask

	task automatic cartless_save();
		int base;
		int mem_base;
		base     = req_lba.size();
		mem_base = mem_reqs;
		cart_en  = 1'b0;
		bk_save  = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		wait_transfer();
		compare_requests(base, BRAM_SECTORS, 1'b1);
		check("memory requests", 32'(mem_reqs - mem_base), 32'd0);
	endtask

	task automatic menu_autosave();
		int base;
		autosave_en = 1'b1;
		check("save_pending", 32'(save_pending), 32'd0);
		bram_addr  = BRAM_ADDR_W'(100);
		bram_wdata = 8'h5a;
		bram_we    = 1'b1;
		@(negedge clk_sys);
		bram_we = 1'b0;
		check("save_pending", 32'(save_pending), 32'd1);
		base       = req_lba.size();
		osd_status = 1'b1;
		@(negedge clk_sys);
		osd_status = 1'b0;
		wait_transfer();
		compare_requests(base, BRAM_SECTORS, 1'b1);
		check("save_pending", 32'(save_pending), 32'd0);
		check("sd_buff_din sector 0 word 50 low byte", 32'(rx_words[50][7:0]), 32'h5a);
		osd_status = 1'b1;   // Menu closes again, nothing to save
		@(negedge clk_sys);
		osd_status = 1'b0;
		repeat (20) @(negedge clk_sys);
		check("SD requests after idle menu close", 32'(req_lba.size() - base), 32'(BRAM_SECTORS));
		check("bk_busy", 32'(bk_busy), 32'd0);
		cart_ram_wr = 1'b1;   // Cart RAM write marks a save too
		@(negedge clk_sys);
		cart_ram_wr = 1'b0;
		check("save_pending after cart RAM write", 32'(save_pending), 32'd1);
	endtask

	initial begin
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		mount_gating();
		full_load();
		full_save();
		cartless_save();
		menu_autosave();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== flist.f ====
common/bkram_pkg.sv
design/sector_ram.sv
design/cart_copier.sv
bkram_ctrl/save_tracker.sv
bkram_ctrl/bkram_ctrl.sv
design/bkram_top.sv
tests/bkram_chk.sv
tests/bkram_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module bkram_tb -o bkram_sim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/bkram_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "FAIL: run ended without a result"; exit 1; }
echo "PASS"
